//--- src/axi_mem_pkg.sv
package axi_mem_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int unsigned AddrWidth = 48;
    localparam int unsigned DataWidth = 64;
    localparam int unsigned IdWidth   = 6;
    localparam int unsigned LenWidth  = 8;

    // Read response buffer entries
    localparam int unsigned BufDepth = 2;

    // ----------------------------------------
    // Derived sizes
    // ----------------------------------------
    localparam int unsigned StrbWidth = DataWidth / 8;
    localparam int unsigned BeatBytes = DataWidth / 8;

    // Beat counter holds len + 1, so one bit wider than len
    localparam int unsigned BeatCntWidth = LenWidth + 1;

    localparam int unsigned BufPtrWidth = $clog2(BufDepth);
    localparam int unsigned BufCntWidth = $clog2(BufDepth + 1);

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [AddrWidth-1:0] axi_addr_t;
    typedef logic [DataWidth-1:0] axi_data_t;
    typedef logic [StrbWidth-1:0] axi_strb_t;
    typedef logic [IdWidth-1:0]   axi_id_t;
    typedef logic [LenWidth-1:0]  axi_len_t;

    // Controller states, one burst at a time
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WRITE_RESP,
        READ
    } ctrl_state_e;

endpackage

//--- src/burst_if.sv
interface burst_if;
    import axi_mem_pkg::*;

    // Burst start, from the controller
    logic      load;
    axi_addr_t start_addr;
    axi_len_t  start_len;
    logic      step;

    // Current beat, from the address generator
    axi_addr_t cur_addr;
    logic      last;

    modport ctrl (
        output load,
        output start_addr,
        output start_len,
        output step,
        input  cur_addr,
        input  last
    );

    modport gen (
        input  load,
        input  start_addr,
        input  start_len,
        input  step,
        output cur_addr,
        output last
    );

endinterface

//--- src/burst_addr_gen.sv
module burst_addr_gen (
    input logic   clk_i,
    input logic   rst_ni,
    burst_if.gen  burst
);
    import axi_mem_pkg::*;

    axi_addr_t               addr_q;
    logic [BeatCntWidth-1:0] cnt_q;

    // Beat counter, zero while no burst is loaded
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (burst.load) begin
            cnt_q <= BeatCntWidth'(burst.start_len) + BeatCntWidth'(1);
        end else if (burst.step) begin
            cnt_q <= cnt_q - BeatCntWidth'(1);
        end
    end

    // INCR address, one full beat per step
    always_ff @(posedge clk_i) begin
        if (burst.load) begin
            addr_q <= burst.start_addr;
        end else if (burst.step) begin
            addr_q <= addr_q + AddrWidth'(BeatBytes);
        end
    end

    assign burst.cur_addr = addr_q;
    assign burst.last     = (cnt_q == BeatCntWidth'(1));

    // Controller must only step inside a loaded burst
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        burst.step |-> (cnt_q != '0))
        else $error("burst step without a loaded burst");

endmodule

//--- src/rsp_buf.sv
module rsp_buf (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Credits for reads issued to memory
    input  logic                  take_i,
    output logic                  credit_o,
    // Read data returning from memory
    input  logic                  push_i,
    input  axi_mem_pkg::axi_data_t push_data_i,
    input  axi_mem_pkg::axi_id_t   push_id_i,
    input  logic                  push_last_i,
    // R channel
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    output axi_mem_pkg::axi_data_t r_data_o,
    output axi_mem_pkg::axi_id_t   r_id_o,
    output logic                  r_last_o
);
    import axi_mem_pkg::*;

    axi_data_t data_q [BufDepth];
    axi_id_t   id_q   [BufDepth];
    logic      last_q [BufDepth];

    logic [BufPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
    logic [BufCntWidth-1:0] count_q, credit_q;
    logic                   pop;

    function automatic logic [BufPtrWidth-1:0] ptr_inc(input logic [BufPtrWidth-1:0] ptr);
        if (ptr == BufPtrWidth'(BufDepth - 1)) begin
            return '0;
        end
        return ptr + BufPtrWidth'(1);
    endfunction

    assign pop = r_valid_o && r_ready_i;

    // ----------------------------------------
    // Pointers, fill level and credits
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q  <= count_q + BufCntWidth'(push_i) - BufCntWidth'(pop);
            // In flight or stored
            credit_q <= credit_q + BufCntWidth'(take_i) - BufCntWidth'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            data_q[wr_ptr_q] <= push_data_i;
            id_q[wr_ptr_q]   <= push_id_i;
            last_q[wr_ptr_q] <= push_last_i;
        end
    end

    assign credit_o  = (credit_q < BufCntWidth'(BufDepth));
    assign r_valid_o = (count_q != '0);
    assign r_data_o  = data_q[rd_ptr_q];
    assign r_id_o    = id_q[rd_ptr_q];
    assign r_last_o  = last_q[rd_ptr_q];

    // Credit accounting must keep the FIFO from overflowing
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> (count_q < BufCntWidth'(BufDepth)))
        else $error("read response pushed into a full buffer");

endmodule

//--- src/axi_mem_ctrl.sv
module axi_mem_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    burst_if.ctrl                  burst,
    // AW channel
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_mem_pkg::axi_id_t   aw_id_i,
    input  axi_mem_pkg::axi_addr_t aw_addr_i,
    input  axi_mem_pkg::axi_len_t  aw_len_i,
    // W channel
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    input  axi_mem_pkg::axi_data_t w_data_i,
    input  axi_mem_pkg::axi_strb_t w_strb_i,
    input  logic                   w_last_i,
    // B channel
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output axi_mem_pkg::axi_id_t   b_id_o,
    // AR channel
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  axi_mem_pkg::axi_id_t   ar_id_i,
    input  axi_mem_pkg::axi_addr_t ar_addr_i,
    input  axi_mem_pkg::axi_len_t  ar_len_i,
    // Memory request side
    output logic                   mem_req_o,
    input  logic                   mem_gnt_i,
    output logic                   mem_we_o,
    output axi_mem_pkg::axi_addr_t mem_addr_o,
    output axi_mem_pkg::axi_data_t mem_wdata_o,
    output axi_mem_pkg::axi_strb_t mem_be_o,
    // Response buffer
    input  logic                   buf_credit_i,
    output logic                   buf_take_o,
    output axi_mem_pkg::axi_id_t   rd_id_o,
    output logic                   rd_last_o
);
    import axi_mem_pkg::*;

    ctrl_state_e state_q, state_d;
    logic        last_rd_q;
    axi_id_t     id_q;
    logic        pick_wr, pick_rd;
    logic        aw_hs, ar_hs;
    logic        grant, rd_grant;

    // ----------------------------------------
    // Arbitration between AW and AR
    // ----------------------------------------
    // Round robin only matters under contention
    assign pick_wr = aw_valid_i && (!ar_valid_i || last_rd_q);
    assign pick_rd = ar_valid_i && !pick_wr;

    assign aw_ready_o = (state_q == IDLE) && pick_wr;
    assign ar_ready_o = (state_q == IDLE) && pick_rd;
    assign aw_hs      = aw_valid_i && aw_ready_o;
    assign ar_hs      = ar_valid_i && ar_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_rd_q <= 1'b1;
        end else if ((state_q == IDLE) && aw_valid_i && ar_valid_i) begin
            last_rd_q <= pick_rd;
        end
    end

    // Burst start
    assign burst.load       = aw_hs || ar_hs;
    assign burst.start_addr = pick_wr ? aw_addr_i : ar_addr_i;
    assign burst.start_len  = pick_wr ? aw_len_i : ar_len_i;

    always_ff @(posedge clk_i) begin
        if (burst.load) begin
            id_q <= pick_wr ? aw_id_i : ar_id_i;
        end
    end

    // ----------------------------------------
    // Beat issue
    // ----------------------------------------
    assign mem_req_o   = ((state_q == WRITE) && w_valid_i) ||
                         ((state_q == READ) && buf_credit_i);
    assign mem_we_o    = (state_q == WRITE);
    assign mem_addr_o  = burst.cur_addr;
    assign mem_wdata_o = w_data_i;
    assign mem_be_o    = (state_q == WRITE) ? w_strb_i : '1;

    assign grant      = mem_req_o && mem_gnt_i;
    assign rd_grant   = grant && (state_q == READ);
    assign burst.step = grant;
    assign buf_take_o = rd_grant;

    // Write data is accepted exactly when memory takes it
    assign w_ready_o = (state_q == WRITE) && mem_gnt_i;

    assign b_valid_o = (state_q == WRITE_RESP);
    assign b_id_o    = id_q;

    // Tag travels alongside the one-cycle read latency
    always_ff @(posedge clk_i) begin
        if (rd_grant) begin
            rd_id_o   <= id_q;
            rd_last_o <= burst.last;
        end
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (aw_hs) begin
                    state_d = WRITE;
                end else if (ar_hs) begin
                    state_d = READ;
                end
            end
            WRITE: begin
                if (grant && burst.last) begin
                    state_d = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (b_ready_i) begin
                    state_d = IDLE;
                end
            end
            READ: begin
                if (rd_grant && burst.last) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (b_valid_o && !b_ready_i) |=> b_valid_o)
        else $error("b_valid_o dropped before b_ready_i");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && (state_q == READ)) |-> buf_credit_i)
        else $error("read issued without a free buffer credit");

    // Master's w_last must agree with the beat counter
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (w_valid_i && w_ready_o) |-> (w_last_i == burst.last))
        else $error("w_last_i does not match the burst length");

endmodule

//--- src/axi_to_mem_adapter.sv
module axi_to_mem_adapter (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // AW channel
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_mem_pkg::axi_id_t   aw_id_i,
    input  axi_mem_pkg::axi_addr_t aw_addr_i,
    input  axi_mem_pkg::axi_len_t  aw_len_i,
    // W channel
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    input  axi_mem_pkg::axi_data_t w_data_i,
    input  axi_mem_pkg::axi_strb_t w_strb_i,
    input  logic                   w_last_i,
    // B channel
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output axi_mem_pkg::axi_id_t   b_id_o,
    // AR channel
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  axi_mem_pkg::axi_id_t   ar_id_i,
    input  axi_mem_pkg::axi_addr_t ar_addr_i,
    input  axi_mem_pkg::axi_len_t  ar_len_i,
    // R channel
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output axi_mem_pkg::axi_id_t   r_id_o,
    output axi_mem_pkg::axi_data_t r_data_o,
    output logic                   r_last_o,
    // Memory port
    output logic                   mem_req_o,
    input  logic                   mem_gnt_i,
    output logic                   mem_we_o,
    output axi_mem_pkg::axi_addr_t mem_addr_o,
    output axi_mem_pkg::axi_data_t mem_wdata_o,
    output axi_mem_pkg::axi_strb_t mem_be_o,
    input  logic                   mem_rvalid_i,
    input  axi_mem_pkg::axi_data_t mem_rdata_i
);
    import axi_mem_pkg::*;

    logic    buf_credit;
    logic    buf_take;
    axi_id_t rd_id;
    logic    rd_last;

    burst_if u_burst ();

    // ----------------------------------------
    // Control and address path
    // ----------------------------------------
    axi_mem_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .burst        (u_burst.ctrl),
        .aw_valid_i   (aw_valid_i),
        .aw_ready_o   (aw_ready_o),
        .aw_id_i      (aw_id_i),
        .aw_addr_i    (aw_addr_i),
        .aw_len_i     (aw_len_i),
        .w_valid_i    (w_valid_i),
        .w_ready_o    (w_ready_o),
        .w_data_i     (w_data_i),
        .w_strb_i     (w_strb_i),
        .w_last_i     (w_last_i),
        .b_valid_o    (b_valid_o),
        .b_ready_i    (b_ready_i),
        .b_id_o       (b_id_o),
        .ar_valid_i   (ar_valid_i),
        .ar_ready_o   (ar_ready_o),
        .ar_id_i      (ar_id_i),
        .ar_addr_i    (ar_addr_i),
        .ar_len_i     (ar_len_i),
        .mem_req_o    (mem_req_o),
        .mem_gnt_i    (mem_gnt_i),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_be_o     (mem_be_o),
        .buf_credit_i (buf_credit),
        .buf_take_o   (buf_take),
        .rd_id_o      (rd_id),
        .rd_last_o    (rd_last)
    );

    burst_addr_gen u_addr_gen (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .burst  (u_burst.gen)
    );

    // Read data path
    rsp_buf u_rsp_buf (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .take_i      (buf_take),
        .credit_o    (buf_credit),
        .push_i      (mem_rvalid_i),
        .push_data_i (mem_rdata_i),
        .push_id_i   (rd_id),
        .push_last_i (rd_last),
        .r_valid_o   (r_valid_o),
        .r_ready_i   (r_ready_i),
        .r_data_o    (r_data_o),
        .r_id_o      (r_id_o),
        .r_last_o    (r_last_o)
    );

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    // Free running clock, period 20
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    // Reset held low over the first 5 rising edges
    initial begin
        rst_no = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- tb/tb_axi_to_mem_adapter.sv
module tb_axi_to_mem_adapter;
    import axi_mem_pkg::*;

    localparam int Timeout  = 1000;
    localparam int MemWords = 2048;
    localparam int NumTxns  = 7;

    typedef enum logic [1:0] {
        WR_ONLY,
        RD_ONLY,
        WR_AND_RD
    } txn_kind_e;

    typedef struct {
        string     name;
        txn_kind_e kind;
        axi_id_t   wr_id;
        axi_id_t   rd_id;
        axi_addr_t wr_addr;
        axi_addr_t rd_addr;
        axi_len_t  len;
        logic      rand_strb;
        int        stall_at;
        int        stall_len;
        logic      wr_first;
    } txn_t;

    logic      clk_i;
    logic      rst_ni;
    logic      aw_valid_i, aw_ready_o;
    axi_id_t   aw_id_i;
    axi_addr_t aw_addr_i;
    axi_len_t  aw_len_i;
    logic      w_valid_i, w_ready_o, w_last_i;
    axi_data_t w_data_i;
    axi_strb_t w_strb_i;
    logic      b_valid_o, b_ready_i;
    axi_id_t   b_id_o;
    logic      ar_valid_i, ar_ready_o;
    axi_id_t   ar_id_i;
    axi_addr_t ar_addr_i;
    axi_len_t  ar_len_i;
    logic      r_valid_o, r_ready_i, r_last_o;
    axi_id_t   r_id_o;
    axi_data_t r_data_o;
    logic      mem_req_o, mem_gnt_i, mem_we_o, mem_rvalid_i;
    axi_addr_t mem_addr_o;
    axi_data_t mem_wdata_o, mem_rdata_i;
    axi_strb_t mem_be_o;

    axi_data_t   mem [MemWords];
    axi_data_t   shadow [MemWords];
    txn_t        txns [NumTxns];
    logic [31:0] data_seed;
    logic [31:0] gnt_seed;
    time         b_done_time, r_first_time, r_last_time;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    axi_to_mem_adapter DUT (.*);

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_data_rand();
        data_seed = xorshift32(data_seed);
        return data_seed;
    endfunction

    // Initial memory contents, unique per word
    function automatic axi_data_t fill_word(input int i);
        return {32'h600D_0000 + 32'(i), ~32'(i)};
    endfunction

    function automatic logic [10:0] word_index(input axi_addr_t a);
        return a[13:3];
    endfunction

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic timeout_stop(input string what);
        $display("Timeout: %s did not complete within %0d cycles", what, Timeout);
        stop_run();
    endtask

    task automatic check_data(input string name, input axi_data_t expected,
                              input axi_data_t actual);
        if (actual !== expected) begin
            $display("Fail %s data: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_id(input string name, input axi_id_t expected, input axi_id_t actual);
        if (actual !== expected) begin
            $display("Fail %s id: expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_last(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s last: expected %b, actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    // ----------------------------------------
    // Burst drivers
    // ----------------------------------------
    task automatic run_write(input string name, input axi_id_t id, input axi_addr_t addr,
                             input axi_len_t len, input logic rand_strb, input int b_stall);
        int          beat;
        int          b;
        int          waited;
        logic [31:0] r;
        axi_data_t   data;
        axi_strb_t   strb;
        logic [10:0] idx;

        aw_valid_i <= 1'b1;
        aw_id_i    <= id;
        aw_addr_i  <= addr;
        aw_len_i   <= len;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > Timeout) begin
                timeout_stop("AW handshake");
            end
        end while (!aw_ready_o);
        aw_valid_i <= 1'b0;

        for (beat = 0; beat <= int'(len); beat++) begin
            data = {next_data_rand(), next_data_rand()};
            r    = next_data_rand();
            strb = rand_strb ? r[StrbWidth-1:0] : '1;
            w_valid_i <= 1'b1;
            w_data_i  <= data;
            w_strb_i  <= strb;
            w_last_i  <= (beat == int'(len));
            waited = 0;
            do begin
                @(posedge clk_i);
                waited++;
                if (waited > Timeout) begin
                    timeout_stop("W beat handshake");
                end
            end while (!w_ready_o);
            // Expected memory image, bytewise
            idx = word_index(addr + AddrWidth'(beat * BeatBytes));
            for (b = 0; b < StrbWidth; b++) begin
                if (strb[b]) begin
                    shadow[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        w_valid_i <= 1'b0;
        w_last_i  <= 1'b0;

        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > Timeout) begin
                timeout_stop("B response");
            end
        end while (!b_valid_o);
        check_id({name, " b_id"}, id, b_id_o);
        repeat (b_stall) @(posedge clk_i);
        b_ready_i <= 1'b1;
        @(posedge clk_i);
        check_flag({name, " b_valid at handshake"}, 1'b1, b_valid_o);
        b_done_time = $time;
        b_ready_i <= 1'b0;
    endtask

    task automatic run_read(input string name, input axi_id_t id, input axi_addr_t addr,
                            input axi_len_t len, input int stall_at, input int stall_len);
        int        beat;
        int        waited;
        int        stall_left;
        logic      stalled;
        axi_addr_t beat_addr;
        string     tag;

        ar_valid_i <= 1'b1;
        ar_id_i    <= id;
        ar_addr_i  <= addr;
        ar_len_i   <= len;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > Timeout) begin
                timeout_stop("AR handshake");
            end
        end while (!ar_ready_o);
        ar_valid_i <= 1'b0;
        r_ready_i  <= 1'b1;

        beat       = 0;
        waited     = 0;
        stall_left = 0;
        stalled    = 1'b0;
        while (beat <= int'(len)) begin
            @(posedge clk_i);
            if (r_valid_o && r_ready_i) begin
                beat_addr = addr + AddrWidth'(beat * BeatBytes);
                tag       = $sformatf("%s beat %0d", name, beat);
                check_data(tag, shadow[word_index(beat_addr)], r_data_o);
                check_id(tag, id, r_id_o);
                check_last(tag, beat == int'(len), r_last_o);
                if (beat == 0) begin
                    r_first_time = $time;
                end
                r_last_time = $time;
                beat++;
                waited = 0;
            end else begin
                waited++;
                if (waited > Timeout) begin
                    timeout_stop("R beat handshake");
                end
            end
            // Back-pressure window on the R channel
            if (!stalled && stall_len > 0 && beat == stall_at) begin
                r_ready_i <= 1'b0;
                stall_left = stall_len;
                stalled    = 1'b1;
            end else if (stall_left > 0) begin
                stall_left--;
                if (stall_left == 0) begin
                    r_ready_i <= 1'b1;
                end
            end
        end
        r_ready_i <= 1'b0;
    endtask

    // ----------------------------------------
    // Memory model
    // ----------------------------------------
    initial begin : memory_model
        int          i;
        int          b;
        int          outstanding;
        logic [10:0] idx;

        for (i = 0; i < MemWords; i++) begin
            mem[i] = fill_word(i);
        end
        outstanding = 0;
        gnt_seed    = 32'd12650;
        mem_gnt_i    <= 1'b0;
        mem_rvalid_i <= 1'b0;
        mem_rdata_i  <= '0;
        forever begin
            @(posedge clk_i);
            // Reads in flight or buffered must leave room in the buffer
            if (mem_req_o && !mem_we_o && outstanding >= int'(BufDepth)) begin
                $display("Error: read request raised with %0d reads outstanding", outstanding);
                stop_run();
            end
            mem_rvalid_i <= 1'b0;
            if (mem_req_o && mem_gnt_i) begin
                idx = word_index(mem_addr_o);
                if (mem_we_o) begin
                    for (b = 0; b < StrbWidth; b++) begin
                        if (mem_be_o[b]) begin
                            mem[idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
                        end
                    end
                end else begin
                    mem_rvalid_i <= 1'b1;
                    mem_rdata_i  <= mem[idx];
                    outstanding++;
                end
            end
            if (r_valid_o && r_ready_i) begin
                outstanding--;
            end
            // About 70% of cycles granted
            gnt_seed = xorshift32(gnt_seed);
            mem_gnt_i <= (gnt_seed % 32'd10) < 32'd7;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        int   n;
        int   waited;
        txn_t t;

        aw_valid_i <= 1'b0;
        aw_id_i    <= '0;
        aw_addr_i  <= '0;
        aw_len_i   <= '0;
        w_valid_i  <= 1'b0;
        w_data_i   <= '0;
        w_strb_i   <= '0;
        w_last_i   <= 1'b0;
        b_ready_i  <= 1'b0;
        ar_valid_i <= 1'b0;
        ar_id_i    <= '0;
        ar_addr_i  <= '0;
        ar_len_i   <= '0;
        r_ready_i  <= 1'b0;
        data_seed = 32'd12650;
        for (n = 0; n < MemWords; n++) begin
            shadow[n] = fill_word(n);
        end

        // name, kind, wr_id, rd_id, wr_addr, rd_addr, len, rand_strb,
        // stall_at, stall_len, wr_first
        txns[0] = '{"single write", WR_ONLY, 6'd5, 6'd0, 48'h100, 48'h0, 8'd0, 1'b0, 0, 3, 1'b0};
        txns[1] = '{"single read", RD_ONLY, 6'd0, 6'd9, 48'h0, 48'h100, 8'd0, 1'b0, 0, 0, 1'b0};
        txns[2] = '{"burst write", WR_ONLY, 6'd12, 6'd0, 48'h200, 48'h0, 8'd7, 1'b1, 0, 0, 1'b0};
        txns[3] = '{"burst read", RD_ONLY, 6'd0, 6'd13, 48'h0, 48'h200, 8'd7, 1'b0, 3, 2, 1'b0};
        txns[4] = '{"stalled read", RD_ONLY, 6'd0, 6'd21, 48'h0, 48'h100, 8'd15, 1'b0, 4, 20,
                    1'b0};
        txns[5] = '{"contention a", WR_AND_RD, 6'd30, 6'd31, 48'h400, 48'h200, 8'd3, 1'b1, 0, 2,
                    1'b1};
        txns[6] = '{"contention b", WR_AND_RD, 6'd32, 6'd33, 48'h500, 48'h400, 8'd3, 1'b1, 0, 0,
                    1'b0};

        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > Timeout) begin
                timeout_stop("reset release");
            end
        end while (!rst_ni);

        // Quiet bus right after reset
        repeat (3) begin
            @(posedge clk_i);
            check_flag("reset aw_ready_o", 1'b0, aw_ready_o);
            check_flag("reset ar_ready_o", 1'b0, ar_ready_o);
            check_flag("reset b_valid_o", 1'b0, b_valid_o);
            check_flag("reset r_valid_o", 1'b0, r_valid_o);
            check_flag("reset mem_req_o", 1'b0, mem_req_o);
        end

        for (n = 0; n < NumTxns; n++) begin
            t = txns[n];
            case (t.kind)
                WR_ONLY: begin
                    run_write(t.name, t.wr_id, t.wr_addr, t.len, t.rand_strb, t.stall_len);
                end
                RD_ONLY: begin
                    run_read(t.name, t.rd_id, t.rd_addr, t.len, t.stall_at, t.stall_len);
                end
                default: begin
                    fork
                        run_write(t.name, t.wr_id, t.wr_addr, t.len, t.rand_strb, t.stall_len);
                        run_read(t.name, t.rd_id, t.rd_addr, t.len, 0, 0);
                    join
                    if (t.wr_first) begin
                        check_flag({t.name, " B before first R"}, 1'b1,
                                   b_done_time < r_first_time);
                    end else begin
                        check_flag({t.name, " last R before B"}, 1'b1,
                                   r_last_time < b_done_time);
                    end
                end
            endcase
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- axi_to_mem_adapter.f
src/axi_mem_pkg.sv
src/burst_if.sv
src/burst_addr_gen.sv
src/rsp_buf.sv
src/axi_mem_ctrl.sv
src/axi_to_mem_adapter.sv
tb/tb_clk_gen.sv
tb/tb_axi_to_mem_adapter.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_to_mem_adapter \
    -f axi_to_mem_adapter.f -o sim_tb &&
{ out="$(./obj_dir/sim_tb 2>&1)"; printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -qx '>>> PASS' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
